/* design/cpu_timing_top.sv */
/* CPU timing top
   Panel conditioning, instruction decode, break arbiter and major-state sequencer */
`default_nettype none

module cpu_timing_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cont_key,
    input  logic                   halt_sw,
    input  logic                   step_sw,
    input  logic                   trigger_sw,
    input  pdp8_pkg::word_t        instruction,
    input  logic                   eae_mode,
    input  logic                   eae_loop,
    input  logic                   index_incr,
    input  logic                   user_flag,
    input  logic                   int_req,
    input  logic                   int_ena,
    input  logic                   int_inh,
    input  logic                   disk_req,
    input  logic                   to_disk,
    output pdp8_pkg::major_state_t state,
    output logic                   int_in_prog,
    output logic                   break_in_prog,
    output logic                   break_to_disk
);

    logic cont;
    logic halt;
    logic single_step;
    logic trigger;
    logic data_break;
    logic is_halt_op;
    logic is_ion_wait;
    logic eae_ext;
    logic eae_a_long;
    logic eae_a_nop;
    logic eae_b_long;
    logic eae_b_double;
    logic eae_b_short;
    logic mem_ref_defer;
    logic jmp_direct;
    logic jms_direct;
    logic is_opr_iot;
    logic is_mul_div;
    logic is_jmp_indirect;

    panel_control u_panel_control (
        .clk         (clk),
        .reset       (reset),
        .cont_key    (cont_key),
        .halt_sw     (halt_sw),
        .step_sw     (step_sw),
        .trigger_sw  (trigger_sw),
        .cont        (cont),
        .halt        (halt),
        .single_step (single_step),
        .trigger     (trigger)
    );

    instr_class_decode u_instr_class_decode (
        .instruction     (instruction),
        .eae_mode        (eae_mode),
        .is_halt_op      (is_halt_op),
        .is_ion_wait     (is_ion_wait),
        .eae_ext         (eae_ext),
        .eae_a_long      (eae_a_long),
        .eae_a_nop       (eae_a_nop),
        .eae_b_long      (eae_b_long),
        .eae_b_double    (eae_b_double),
        .eae_b_short     (eae_b_short),
        .mem_ref_defer   (mem_ref_defer),
        .jmp_direct      (jmp_direct),
        .jms_direct      (jms_direct),
        .is_opr_iot      (is_opr_iot),
        .is_mul_div      (is_mul_div),
        .is_jmp_indirect (is_jmp_indirect)
    );

    data_break_arbiter u_data_break_arbiter (
        .clk           (clk),
        .reset         (reset),
        .disk_req      (disk_req),
        .to_disk       (to_disk),
        .break_in_prog (break_in_prog),
        .data_break    (data_break),
        .break_to_disk (break_to_disk)
    );

    major_state_seq u_major_state_seq (
        .clk             (clk),
        .reset           (reset),
        .cont            (cont),
        .halt            (halt),
        .single_step     (single_step),
        .trigger         (trigger),
        .is_halt_op      (is_halt_op),
        .is_ion_wait     (is_ion_wait),
        .eae_ext         (eae_ext),
        .eae_a_long      (eae_a_long),
        .eae_a_nop       (eae_a_nop),
        .eae_b_long      (eae_b_long),
        .eae_b_double    (eae_b_double),
        .eae_b_short     (eae_b_short),
        .mem_ref_defer   (mem_ref_defer),
        .jmp_direct      (jmp_direct),
        .jms_direct      (jms_direct),
        .is_opr_iot      (is_opr_iot),
        .is_mul_div      (is_mul_div),
        .is_jmp_indirect (is_jmp_indirect),
        .int_req         (int_req),
        .int_ena         (int_ena),
        .int_inh         (int_inh),
        .user_flag       (user_flag),
        .index_incr      (index_incr),
        .eae_loop        (eae_loop),
        .data_break      (data_break),
        .state           (state),
        .int_in_prog     (int_in_prog),
        .break_in_prog   (break_in_prog)
    );

endmodule

`default_nettype wire

/* design/data_break_arbiter.sv */
/* Data-break arbiter
   Holds a disk break request and its direction until the sequencer completes DB2 */
`default_nettype none

module data_break_arbiter (
    input  logic clk,
    input  logic reset,
    input  logic disk_req,
    input  logic to_disk,
    input  logic break_in_prog,
    output logic data_break,
    output logic break_to_disk
);

    logic break_seen;   // break_in_prog one cycle late

    always_ff @(posedge clk) begin
        if (reset) begin
            break_seen    <= 1'b0;
            data_break    <= 1'b0;
            break_to_disk <= 1'b0;
        end else begin
            break_seen <= break_in_prog;
            if (break_seen & ~break_in_prog) begin
                data_break <= 1'b0;            // Break served
            end else if (disk_req & ~data_break) begin
                data_break    <= 1'b1;
                break_to_disk <= to_disk;
            end
        end
    end

    a_dir_stable: assert property (@(posedge clk) disable iff (reset)
        data_break |=> !data_break || $stable(break_to_disk));

endmodule

`default_nettype wire

/* design/instr_class_decode.sv */
/* Instruction class decode
   Sorts the current instruction into the classes the major-state sequencer branches on */
`default_nettype none

module instr_class_decode (
    input  pdp8_pkg::word_t instruction,
    input  logic            eae_mode,
    output logic            is_halt_op,
    output logic            is_ion_wait,
    output logic            eae_ext,
    output logic            eae_a_long,
    output logic            eae_a_nop,
    output logic            eae_b_long,
    output logic            eae_b_double,
    output logic            eae_b_short,
    output logic            mem_ref_defer,
    output logic            jmp_direct,
    output logic            jms_direct,
    output logic            is_opr_iot,
    output logic            is_mul_div,
    output logic            is_jmp_indirect
);

    pdp8_pkg::opcode_t opcode;
    logic              a_long_pat;
    logic              b_long_pat;
    logic              b_double_pat;

    assign opcode = instruction[0:2];

    assign is_opr_iot      = opcode[0:1] == pdp8_pkg::OP_OPR_IOT[0:1];
    assign mem_ref_defer   = instruction[3] & ~(opcode[0] & opcode[1]);  // Indirect mem ref or jump
    assign jmp_direct      = (opcode == pdp8_pkg::OP_JMP) & ~instruction[3];
    assign jms_direct      = (opcode == pdp8_pkg::OP_JMS) & ~instruction[3];
    assign is_jmp_indirect = (opcode == pdp8_pkg::OP_JMP) & instruction[3];

    assign is_halt_op  = (instruction & pdp8_pkg::INSTR_HLT_MASK) == pdp8_pkg::INSTR_HLT_VALUE;
    assign is_ion_wait = instruction == pdp8_pkg::INSTR_ION_WAIT;
    assign is_mul_div  = (instruction & pdp8_pkg::EAE_MUL_DIV_MASK)
                         == pdp8_pkg::EAE_MUL_DIV_VALUE;

    // Group 3 with an EAE function, except plain NOP and SWBA
    assign eae_ext = (instruction ==? 12'b1111???????1)
                     & ~(instruction ==? 12'b1111??0?0001)
                     & ~(instruction ==? 12'b1111??1?0111);

    // Mode A operations that run the EAE loop
    assign a_long_pat = (instruction ==? 12'b1111??0?0101)     // MUY
                      | (instruction ==? 12'b1111??0?0111)     // DVI
                      | (instruction ==? 12'b1111??0?1011)     // SHL
                      | (instruction ==? 12'b1111??0?1101)     // ASR
                      | (instruction ==? 12'b1111??0?1111)     // LSR
                      | (instruction ==? 12'b1111??1?0101)
                      | (instruction ==? 12'b1111??1?0111)
                      | (instruction ==? 12'b1111?1111011)
                      | (instruction ==? 12'b1111?1111101)
                      | (instruction ==? 12'b1111??1?1111)
                      | (instruction ==? 12'b1111??1?1001)
                      | (instruction == 12'o7411);             // NMI

    // Mode B shifts and normalize
    assign b_long_pat = (instruction == 12'o7411)
                      | (instruction ==? 12'b1111??0?1011)
                      | (instruction ==? 12'b1111??0?1101)
                      | (instruction ==? 12'b1111??0?1111);

    // Mode B operations with a memory operand, routed through D
    assign b_double_pat = (instruction ==? 12'b1111??0?0101)   // MUY
                        | (instruction ==? 12'b1111??0?0111)   // DVI
                        | (instruction ==? 12'b1111??1?0011)   // DAD, DLD
                        | (instruction ==? 12'b1111??1?0101);  // DST

    assign eae_a_long   = eae_ext & ~eae_mode & a_long_pat;
    assign eae_a_nop    = eae_ext & ~eae_mode & ~a_long_pat;
    assign eae_b_long   = eae_ext & eae_mode & b_long_pat;
    assign eae_b_double = eae_ext & eae_mode & b_double_pat;
    assign eae_b_short  = eae_ext & eae_mode & ~b_long_pat & ~b_double_pat;

endmodule

`default_nettype wire

/* design/major_state_seq.sv */
/* Major-state sequencer
   Fetch, defer, execute, halt, EAE and data-break cycles with interrupt entry */
`default_nettype none

module major_state_seq (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cont,
    input  logic                   halt,
    input  logic                   single_step,
    input  logic                   trigger,
    input  logic                   is_halt_op,
    input  logic                   is_ion_wait,
    input  logic                   eae_ext,
    input  logic                   eae_a_long,
    input  logic                   eae_a_nop,
    input  logic                   eae_b_long,
    input  logic                   eae_b_double,
    input  logic                   eae_b_short,
    input  logic                   mem_ref_defer,
    input  logic                   jmp_direct,
    input  logic                   jms_direct,
    input  logic                   is_opr_iot,
    input  logic                   is_mul_div,
    input  logic                   is_jmp_indirect,
    input  logic                   int_req,
    input  logic                   int_ena,
    input  logic                   int_inh,
    input  logic                   user_flag,
    input  logic                   index_incr,
    input  logic                   eae_loop,
    input  logic                   data_break,
    output pdp8_pkg::major_state_t state,
    output logic                   int_in_prog,
    output logic                   break_in_prog
);

    pdp8_pkg::major_state_t state_next;
    pdp8_pkg::major_state_t succ;        // Successor at a cycle end
    pdp8_pkg::major_state_t ret_state;   // Where a data break resumes
    logic                   cycle_end;
    logic                   int_set;
    logic                   int_take;
    logic                   break_start;

    assign int_take    = int_req & int_ena & ~int_inh;
    assign break_start = cycle_end & data_break;

    always_comb begin
        state_next = state;
        succ       = state;
        cycle_end  = 1'b0;
        int_set    = 1'b0;
        case (state)
            pdp8_pkg::F0: begin
                if (single_step & ~cont) begin
                    state_next = pdp8_pkg::F0;
                end else if (halt & ~cont) begin
                    state_next = pdp8_pkg::H0;
                end else begin
                    state_next = pdp8_pkg::FW;
                end
            end
            pdp8_pkg::FW: state_next = pdp8_pkg::F1;
            pdp8_pkg::F1: begin
                if (eae_a_long | eae_a_nop) begin
                    state_next = pdp8_pkg::F2A;
                end else if (eae_ext) begin
                    state_next = pdp8_pkg::F2B;
                end else begin
                    state_next = pdp8_pkg::F2;
                end
            end
            pdp8_pkg::F2:  state_next = pdp8_pkg::F3;
            pdp8_pkg::F2A: state_next = eae_a_long ? pdp8_pkg::EAE0 : pdp8_pkg::F3;
            pdp8_pkg::F2B: begin
                if (eae_b_long) begin
                    state_next = pdp8_pkg::EAE0;
                end else if (eae_b_double) begin
                    state_next = pdp8_pkg::D0;     // Double operand fetched in D
                end else begin
                    state_next = pdp8_pkg::F3;
                end
            end
            pdp8_pkg::F3: begin
                cycle_end = 1'b1;
                if (is_halt_op & ~user_flag) begin
                    succ = pdp8_pkg::H0;           // User mode traps HLT instead
                end else if (is_opr_iot | jmp_direct) begin
                    if (int_take & ~is_ion_wait) begin
                        succ    = pdp8_pkg::E0;
                        int_set = 1'b1;
                    end else begin
                        succ = pdp8_pkg::F0;
                    end
                end else if (mem_ref_defer) begin
                    succ = pdp8_pkg::D0;
                end else begin
                    succ = pdp8_pkg::E0;           // Direct AND TAD ISZ DCA, JMS stores in E
                end
            end
            pdp8_pkg::D0: state_next = (~single_step | cont) ? pdp8_pkg::DW : pdp8_pkg::D0;
            pdp8_pkg::DW: state_next = index_incr ? pdp8_pkg::D1 : pdp8_pkg::D3;
            pdp8_pkg::D1: state_next = pdp8_pkg::D2;
            pdp8_pkg::D2: state_next = pdp8_pkg::D3;
            pdp8_pkg::D3: begin
                cycle_end = 1'b1;
                if (is_jmp_indirect & int_take) begin
                    succ    = pdp8_pkg::E0;
                    int_set = 1'b1;
                end else if (is_jmp_indirect) begin
                    succ = pdp8_pkg::F0;
                end else begin
                    succ = pdp8_pkg::E0;
                end
            end
            pdp8_pkg::E0: state_next = (~single_step | cont) ? pdp8_pkg::EW : pdp8_pkg::E0;
            pdp8_pkg::EW: state_next = pdp8_pkg::E1;
            pdp8_pkg::E1: state_next = is_mul_div ? pdp8_pkg::EAE0 : pdp8_pkg::E2;
            pdp8_pkg::E2: state_next = pdp8_pkg::E3;
            pdp8_pkg::E3: begin
                cycle_end = 1'b1;
                if (int_take & ~int_in_prog) begin
                    succ    = pdp8_pkg::E0;        // Interrupt entry
                    int_set = 1'b1;
                end else begin
                    succ = pdp8_pkg::F0;
                end
            end
            pdp8_pkg::H0: state_next = pdp8_pkg::HW;
            pdp8_pkg::HW: begin
                cycle_end = 1'b1;
                if (cont) begin
                    succ = pdp8_pkg::F0;
                end else if (trigger) begin
                    succ = pdp8_pkg::H1;
                end else begin
                    succ = pdp8_pkg::HW;
                end
            end
            pdp8_pkg::H1:   state_next = pdp8_pkg::H2;
            pdp8_pkg::H2:   state_next = pdp8_pkg::H3;
            pdp8_pkg::H3:   state_next = pdp8_pkg::H0;
            pdp8_pkg::EAE0: state_next = pdp8_pkg::EAE1;
            pdp8_pkg::EAE1: state_next = eae_loop ? pdp8_pkg::EAE1 : pdp8_pkg::F3;
            pdp8_pkg::DB0:  state_next = pdp8_pkg::DB1;
            pdp8_pkg::DB1:  state_next = pdp8_pkg::DB2;
            pdp8_pkg::DB2:  state_next = ret_state;
            default:        state_next = pdp8_pkg::H0;
        endcase
        if (cycle_end) begin
            state_next = data_break ? pdp8_pkg::DB0 : succ;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= pdp8_pkg::H0;
            int_in_prog   <= 1'b0;
            break_in_prog <= 1'b0;
        end else begin
            state <= state_next;
            if (break_start) begin
                break_in_prog <= 1'b1;             // Entering DB0
            end else if (state == pdp8_pkg::DB2) begin
                break_in_prog <= 1'b0;
            end
            if (state == pdp8_pkg::F0) begin
                int_in_prog <= 1'b0;
            end else if (int_set) begin
                int_in_prog <= 1'b1;
            end
        end
    end

    // A break taken while halted resumes through H0 so the request has time to clear
    always_ff @(posedge clk) begin
        if (break_start) begin
            ret_state <= (succ == pdp8_pkg::HW) ? pdp8_pkg::H0 : succ;
        end
    end

    a_break_flag: assert property (@(posedge clk) disable iff (reset)
        break_in_prog == (state inside {pdp8_pkg::DB0, pdp8_pkg::DB1, pdp8_pkg::DB2}));

    a_bad_state: assert property (@(posedge clk) disable iff (reset)
        state > pdp8_pkg::DB2 |=> state == pdp8_pkg::H0);

    // Instruction held from F1, so mode B classes stay exclusive
    a_mode_b_class: assert property (@(posedge clk) disable iff (reset)
        state == pdp8_pkg::F2B |-> $onehot({eae_b_long, eae_b_double, eae_b_short}));

endmodule

`default_nettype wire

/* design/panel_control.sv */
/* Front-panel switch conditioning
   Two-flop synchronizers on all keys, continue reduced to a one-cycle pulse */
`default_nettype none

module panel_control (
    input  logic clk,
    input  logic reset,
    input  logic cont_key,
    input  logic halt_sw,
    input  logic step_sw,
    input  logic trigger_sw,
    output logic cont,
    output logic halt,
    output logic single_step,
    output logic trigger
);

    logic [3:0] sync_a;     // First stage, may go metastable
    logic [3:0] sync_b;
    logic       cont_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_a    <= '0;
            sync_b    <= '0;
            cont_last <= 1'b0;
            cont      <= 1'b0;
        end else begin
            sync_a    <= {trigger_sw, step_sw, halt_sw, cont_key};
            sync_b    <= sync_a;
            cont_last <= sync_b[0];
            cont      <= sync_b[0] & ~cont_last;   // Rising edge only
        end
    end

    assign halt        = sync_b[1];
    assign single_step = sync_b[2];
    assign trigger     = sync_b[3];

    // A held key must not look like repeated presses
    a_cont_single: assert property (@(posedge clk) disable iff (reset)
        cont |=> !cont);

endmodule

`default_nettype wire

/* design/pdp8_pkg.sv */
/* PDP-8 timing package
   Word and opcode types, major-state encoding and the instruction patterns the sequencer needs */
`default_nettype none

package pdp8_pkg;

    typedef logic [0:11] word_t;   // Bit 0 is the most significant, PDP-8 style
    typedef logic [0:2]  opcode_t;

    typedef enum logic [4:0] {
        F0,
        FW,
        F1,
        F2,
        F2A,                        // EAE mode A
        F2B,                        // EAE mode B
        F3,
        D0,
        DW,
        D1,
        D2,
        D3,
        E0,
        EW,
        E1,
        E2,
        E3,
        H0,
        HW,
        H1,
        H2,
        H3,
        EAE0,
        EAE1,
        DB0,
        DB1,
        DB2                         // Must stay the last encoding
    } major_state_t;

    localparam opcode_t OP_JMS     = 3'o4;
    localparam opcode_t OP_JMP     = 3'o5;
    localparam opcode_t OP_OPR_IOT = 3'o6;  // IOT and OPR share the top two bits

    // Group 2 operate with HLT set
    localparam word_t INSTR_HLT_MASK  = 12'o7403;
    localparam word_t INSTR_HLT_VALUE = 12'o7402;

    // IOF right after ION must not let an interrupt in
    localparam word_t INSTR_ION_WAIT = 12'o6002;

    localparam word_t EAE_MUL_DIV_MASK  = 12'o7455;
    localparam word_t EAE_MUL_DIV_VALUE = 12'o7405;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the CPU timing testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f verilog.f --top-module tb_cpu_timing -o sim_cpu_timing

./obj_dir/sim_cpu_timing | tee sim.log

if grep -q "^All checks passed$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

/* test/tb_cpu_timing.sv */
/* CPU timing testbench
   Runs a table of instructions through the major-state sequencer and checks every state */
`default_nettype none

module tb_cpu_timing;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS = 10;
    localparam int MAX_SEQ  = 16;
    localparam int CLK_HALF = 10;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   cont_key;
    logic                   halt_sw;
    logic                   step_sw;
    logic                   trigger_sw;
    pdp8_pkg::word_t        instruction;
    logic                   eae_mode;
    logic                   eae_loop;
    logic                   index_incr;
    logic                   user_flag;
    logic                   int_req;
    logic                   int_ena;
    logic                   int_inh;
    logic                   disk_req;
    logic                   to_disk;
    pdp8_pkg::major_state_t state;
    logic                   int_in_prog;
    logic                   break_in_prog;
    logic                   break_to_disk;

    pdp8_pkg::word_t        row_instr [NUM_ROWS];
    logic [2:0]             row_int   [NUM_ROWS];   // req, ena, inh
    logic                   row_index [NUM_ROWS];
    logic                   row_user  [NUM_ROWS];
    logic                   row_mode  [NUM_ROWS];
    int                     row_loops [NUM_ROWS];   // EAE1 cycles
    logic                   row_disk  [NUM_ROWS];
    logic                   row_dir   [NUM_ROWS];
    int                     row_len   [NUM_ROWS];
    pdp8_pkg::major_state_t exp_seq   [NUM_ROWS][MAX_SEQ];

    int                     errors;
    int                     eae1_count;
    logic                   break_sent;
    logic                   exp_int;                // Interrupt-in-progress model
    pdp8_pkg::major_state_t prev_exp;

    cpu_timing_top u_cpu_timing_top (
        .clk           (clk),
        .reset         (reset),
        .cont_key      (cont_key),
        .halt_sw       (halt_sw),
        .step_sw       (step_sw),
        .trigger_sw    (trigger_sw),
        .instruction   (instruction),
        .eae_mode      (eae_mode),
        .eae_loop      (eae_loop),
        .index_incr    (index_incr),
        .user_flag     (user_flag),
        .int_req       (int_req),
        .int_ena       (int_ena),
        .int_inh       (int_inh),
        .disk_req      (disk_req),
        .to_disk       (to_disk),
        .state         (state),
        .int_in_prog   (int_in_prog),
        .break_in_prog (break_in_prog),
        .break_to_disk (break_to_disk)
    );

    always #CLK_HALF clk = ~clk;

    initial begin
        #((NUM_ROWS * 40 + 200) * 2 * CLK_HALF);
        $display("Timeout, the sequencer did not finish the table in time");
        $display("Checks failed");
        $finish;
    end

    task automatic set_row(input int r, input pdp8_pkg::word_t instr, input logic [2:0] irq,
                           input logic idx, input logic user, input logic mode,
                           input int loops, input logic disk, input logic dir, input int len);
        row_instr[r] = instr;
        row_int[r]   = irq;
        row_index[r] = idx;
        row_user[r]  = user;
        row_mode[r]  = mode;
        row_loops[r] = loops;
        row_disk[r]  = disk;
        row_dir[r]   = dir;
        row_len[r]   = len;
    endtask

    task automatic load_table();
        set_row(0, 12'o1200, 3'b000, 1'b0, 1'b0, 1'b0, 0, 1'b0, 1'b0, 11);   // TAD direct
        exp_seq[0] = '{pdp8_pkg::F0, pdp8_pkg::FW, pdp8_pkg::F1, pdp8_pkg::F2, pdp8_pkg::F3,
                       pdp8_pkg::E0, pdp8_pkg::EW, pdp8_pkg::E1, pdp8_pkg::E2, pdp8_pkg::E3,
                       pdp8_pkg::F0, pdp8_pkg::H0, pdp8_pkg::H0, pdp8_pkg::H0, pdp8_pkg::H0,
                       pdp8_pkg::H0};
        set_row(1, 12'o1600, 3'b000, 1'b1, 1'b0, 1'b0, 0, 1'b0, 1'b0, 16);   // TAD I, autoindex
        exp_seq[1] = '{pdp8_pkg::F0, pdp8_pkg::FW, pdp8_pkg::F1, pdp8_pkg::F2, pdp8_pkg::F3,
                       pdp8_pkg::D0, pdp8_pkg::DW, pdp8_pkg::D1, pdp8_pkg::D2, pdp8_pkg::D3,
                       pdp8_pkg::E0, pdp8_pkg::EW, pdp8_pkg::E1, pdp8_pkg::E2, pdp8_pkg::E3,
                       pdp8_pkg::F0};
        set_row(2, 12'o1600, 3'b000, 1'b0, 1'b0, 1'b0, 0, 1'b0, 1'b0, 14);   // TAD I
        exp_seq[2] = '{pdp8_pkg::F0, pdp8_pkg::FW, pdp8_pkg::F1, pdp8_pkg::F2, pdp8_pkg::F3,
                       pdp8_pkg::D0, pdp8_pkg::DW, pdp8_pkg::D3, pdp8_pkg::E0, pdp8_pkg::EW,
                       pdp8_pkg::E1, pdp8_pkg::E2, pdp8_pkg::E3, pdp8_pkg::F0, pdp8_pkg::H0,
                       pdp8_pkg::H0};
        set_row(3, 12'o5600, 3'b000, 1'b0, 1'b0, 1'b0, 0, 1'b0, 1'b0, 9);    // JMP I
        exp_seq[3] = '{pdp8_pkg::F0, pdp8_pkg::FW, pdp8_pkg::F1, pdp8_pkg::F2, pdp8_pkg::F3,
                       pdp8_pkg::D0, pdp8_pkg::DW, pdp8_pkg::D3, pdp8_pkg::F0, pdp8_pkg::H0,
                       pdp8_pkg::H0, pdp8_pkg::H0, pdp8_pkg::H0, pdp8_pkg::H0, pdp8_pkg::H0,
                       pdp8_pkg::H0};
        set_row(4, 12'o1200, 3'b110, 1'b0, 1'b0, 1'b0, 0, 1'b0, 1'b0, 16);   // Interrupt taken
        exp_seq[4] = '{pdp8_pkg::F0, pdp8_pkg::FW, pdp8_pkg::F1, pdp8_pkg::F2, pdp8_pkg::F3,
                       pdp8_pkg::E0, pdp8_pkg::EW, pdp8_pkg::E1, pdp8_pkg::E2, pdp8_pkg::E3,
                       pdp8_pkg::E0, pdp8_pkg::EW, pdp8_pkg::E1, pdp8_pkg::E2, pdp8_pkg::E3,
                       pdp8_pkg::F0};
        set_row(5, 12'o1200, 3'b111, 1'b0, 1'b0, 1'b0, 0, 1'b0, 1'b0, 11);   // Inhibited
        exp_seq[5] = exp_seq[0];
        set_row(6, 12'o1200, 3'b000, 1'b0, 1'b0, 1'b0, 0, 1'b1, 1'b1, 14);   // Disk break
        exp_seq[6] = '{pdp8_pkg::F0, pdp8_pkg::FW, pdp8_pkg::F1, pdp8_pkg::F2, pdp8_pkg::F3,
                       pdp8_pkg::E0, pdp8_pkg::EW, pdp8_pkg::E1, pdp8_pkg::E2, pdp8_pkg::E3,
                       pdp8_pkg::DB0, pdp8_pkg::DB1, pdp8_pkg::DB2, pdp8_pkg::F0, pdp8_pkg::H0,
                       pdp8_pkg::H0};
        set_row(7, 12'o7402, 3'b000, 1'b0, 1'b0, 1'b0, 0, 1'b0, 1'b0, 6);    // HLT, executive
        exp_seq[7] = '{pdp8_pkg::F0, pdp8_pkg::FW, pdp8_pkg::F1, pdp8_pkg::F2, pdp8_pkg::F3,
                       pdp8_pkg::H0, pdp8_pkg::H0, pdp8_pkg::H0, pdp8_pkg::H0, pdp8_pkg::H0,
                       pdp8_pkg::H0, pdp8_pkg::H0, pdp8_pkg::H0, pdp8_pkg::H0, pdp8_pkg::H0,
                       pdp8_pkg::H0};
        set_row(8, 12'o7402, 3'b000, 1'b0, 1'b1, 1'b0, 0, 1'b0, 1'b0, 6);    // HLT, user mode
        exp_seq[8] = exp_seq[7];
        exp_seq[8][5] = pdp8_pkg::F0;
        set_row(9, 12'o7405, 3'b000, 1'b0, 1'b0, 1'b0, 3, 1'b0, 1'b0, 10);   // MUY, mode A
        exp_seq[9] = '{pdp8_pkg::F0, pdp8_pkg::FW, pdp8_pkg::F1, pdp8_pkg::F2A, pdp8_pkg::EAE0,
                       pdp8_pkg::EAE1, pdp8_pkg::EAE1, pdp8_pkg::EAE1, pdp8_pkg::F3, pdp8_pkg::F0,
                       pdp8_pkg::H0, pdp8_pkg::H0, pdp8_pkg::H0, pdp8_pkg::H0, pdp8_pkg::H0,
                       pdp8_pkg::H0};
    endtask

    // Compares the registered outputs with the expected state and flags
    task automatic check_outputs(input pdp8_pkg::major_state_t exp_state, input logic exp_dir);
        logic exp_break;
        exp_break = exp_state inside {pdp8_pkg::DB0, pdp8_pkg::DB1, pdp8_pkg::DB2};
        if (prev_exp == pdp8_pkg::F0) begin
            exp_int = 1'b0;                  // Cleared on leaving F0
        end else if (exp_state == pdp8_pkg::E0 && prev_exp == pdp8_pkg::E3) begin
            exp_int = 1'b1;                  // Interrupt entry
        end
        assert (state == exp_state) else begin
            errors++;
            $display("ERR %0t state expected %s actual %s", $time, exp_state.name(),
                     state.name());
        end
        assert (int_in_prog == exp_int) else begin
            errors++;
            $display("ERR %0t int_in_prog expected %0b actual %0b", $time, exp_int,
                     int_in_prog);
        end
        assert (break_in_prog == exp_break) else begin
            errors++;
            $display("ERR %0t break_in_prog expected %0b actual %0b", $time, exp_break,
                     break_in_prog);
        end
        if (exp_break) begin
            assert (break_to_disk == exp_dir) else begin
                errors++;
                $display("ERR %0t break_to_disk expected %0b actual %0b", $time, exp_dir,
                         break_to_disk);
            end
        end
        prev_exp = exp_state;
    endtask

    // Inputs for the next cycle, keyed on the state just checked
    task automatic drive_cycle(input int r, input pdp8_pkg::major_state_t st);
        if (st == pdp8_pkg::EAE1) begin
            eae1_count++;
        end
        eae_loop = (st == pdp8_pkg::EAE0 || st == pdp8_pkg::EAE1)
                   && (eae1_count < row_loops[r]);
        disk_req = row_disk[r] && (st == pdp8_pkg::E0) && !break_sent;   // One-cycle request
        if (disk_req) begin
            break_sent = 1'b1;
        end
    endtask

    task automatic run_row(input int r);
        int waited;
        waited      = 0;
        eae1_count  = 0;
        break_sent  = 1'b0;
        instruction = row_instr[r];
        int_req     = row_int[r][2];
        int_ena     = row_int[r][1];
        int_inh     = row_int[r][0];
        index_incr  = row_index[r];
        user_flag   = row_user[r];
        eae_mode    = row_mode[r];
        eae_loop    = 1'b0;
        disk_req    = 1'b0;
        to_disk     = row_dir[r];
        halt_sw     = 1'b0;
        cont_key    = 1'b1;
        @(negedge clk);
        while (state == pdp8_pkg::HW && waited < 8) begin
            waited++;
            @(negedge clk);
        end
        assert (state != pdp8_pkg::HW) else begin
            errors++;
            $display("Row %0d: continue key did not move the sequencer out of HW", r);
        end
        cont_key = 1'b0;
        halt_sw  = 1'b1;                     // Next F0 stops in H0
        for (int i = 0; i < row_len[r]; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            check_outputs(exp_seq[r][i], row_dir[r]);
            drive_cycle(r, exp_seq[r][i]);
        end
        if (exp_seq[r][row_len[r] - 1] != pdp8_pkg::H0) begin
            @(negedge clk);
            check_outputs(pdp8_pkg::H0, row_dir[r]);
        end
        @(negedge clk);
        check_outputs(pdp8_pkg::HW, row_dir[r]);
    endtask

    initial begin
        errors      = 0;
        eae1_count  = 0;
        break_sent  = 1'b0;
        exp_int     = 1'b0;
        prev_exp    = pdp8_pkg::H0;
        reset       = 1'b1;
        cont_key    = 1'b0;
        halt_sw     = 1'b0;
        step_sw     = 1'b0;
        trigger_sw  = 1'b0;
        instruction = '0;
        eae_mode    = 1'b0;
        eae_loop    = 1'b0;
        index_incr  = 1'b0;
        user_flag   = 1'b0;
        int_req     = 1'b0;
        int_ena     = 1'b0;
        int_inh     = 1'b0;
        disk_req    = 1'b0;
        to_disk     = 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_outputs(pdp8_pkg::H0, 1'b0);
        assert (break_to_disk == 1'b0) else begin
            errors++;
            $display("ERR %0t break_to_disk expected 0 actual %0b", $time, break_to_disk);
        end
        @(negedge clk);
        check_outputs(pdp8_pkg::HW, 1'b0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Run complete, %0d errors over %0d rows", errors, NUM_ROWS);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
design/pdp8_pkg.sv
design/panel_control.sv
design/instr_class_decode.sv
design/data_break_arbiter.sv
design/major_state_seq.sv
design/cpu_timing_top.sv
test/tb_cpu_timing.sv
